/* include/uart_consts.svh */
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// **************************************************
// Serial line timing
// **************************************************

// Clock cycles per serial bit
`define UART_CLKS_PER_BIT 16

// Data bits in one 8N1 frame
`define UART_DATA_BITS 8

// **************************************************
// Buffering
// **************************************************

// FIFO address width, depth is 2**bits with one slot unused
`define UART_FIFO_ADDR_BITS 3

`endif

/* hdl/uartPkg.sv */
`include "uart_consts.svh"

package uartPkg;

	// **************************************************
	// Shared types
	// **************************************************

	// One data byte as it moves between FIFOs and serializers
	typedef logic [`UART_DATA_BITS-1:0] uartByte;

	// Frame position of both serial state machines
	typedef enum logic [1:0] {
		stateIdle,
		stateStart,
		stateData,
		stateStop
	} serialState;

endpackage

/* hdl/byteFifo.sv */
`timescale 1ns/1ns

module byteFifo import uartPkg::*; #(
	parameter int ADDR_BITS = 3
) (
	input logic clk,
	input logic rst,
	input uartByte dataIn,
	input logic we,
	input logic oe,
	output uartByte dataOut,
	output logic isData,
	output logic bufferFull,
	output logic dataLost
);
	localparam int DEPTH = 1 << ADDR_BITS;

	uartByte storage [DEPTH];
	uartByte dataInReg;
	logic weReg;
	logic oeReg;
	logic [ADDR_BITS-1:0] head;
	logic [ADDR_BITS-1:0] tail;
	logic [ADDR_BITS-1:0] nextHead;
	logic [ADDR_BITS-1:0] nextTail;
	logic writeAccept;
	logic readAdvance;

	assign nextHead = head + ADDR_BITS'(1);
	assign nextTail = tail + ADDR_BITS'(1);

	// One slot stays empty so full and empty differ
	assign isData = head != tail;
	assign bufferFull = nextTail == head;

	assign writeAccept = weReg && !bufferFull;
	assign readAdvance = oeReg && isData;

	// Strobes take effect one edge after they are sampled
	always_ff @(posedge clk) begin
		if (rst) begin
			weReg <= 1'b0;
			oeReg <= 1'b0;
		end else begin
			weReg <= we;
			oeReg <= oe;
		end
	end

	always_ff @(posedge clk) begin
		dataInReg <= dataIn;
		if (writeAccept)
			storage[tail] <= dataInReg;
	end

	// **************************************************
	// Pointers, show-ahead output and lost flag
	// **************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			dataOut <= '0;
			dataLost <= 1'b0;
		end else begin
			if (readAdvance) begin
				head <= nextHead;
				// Next head may be the slot being written right now
				if (writeAccept && nextHead == tail)
					dataOut <= dataInReg;
				else
					dataOut <= storage[nextHead];
			end else if (oeReg) begin
				dataOut <= '0;
			end

			if (writeAccept) begin
				tail <= nextTail;
				dataLost <= 1'b0;
				// Empty buffer shows the new byte at once
				if (!isData)
					dataOut <= dataInReg;
			end else if (weReg) begin
				dataLost <= 1'b1;
			end
		end
	end

endmodule

/* hdl/baudTimer.sv */
`timescale 1ns/1ns
`include "uart_consts.svh"

module baudTimer import uartPkg::*; (
	input logic clk,
	input logic rst,
	input logic run,
	input logic halfFirst,
	output logic tick
);
	localparam int PERIOD = `UART_CLKS_PER_BIT;
	localparam int HALF = PERIOD / 2;
	localparam int COUNT_BITS = $clog2(PERIOD + 1);

	logic [COUNT_BITS-1:0] count;
	logic running;

	// Down-counter reloaded once per bit period
	always_ff @(posedge clk) begin
		if (rst || !run) begin
			count <= '0;
			running <= 1'b0;
			tick <= 1'b0;
		end else if (!running) begin
			// First interval, optionally half a bit for mid-bit sampling
			running <= 1'b1;
			tick <= 1'b0;
			if (halfFirst)
				count <= COUNT_BITS'(HALF - 1);
			else
				count <= COUNT_BITS'(PERIOD - 1);
		end else if (count == '0) begin
			count <= COUNT_BITS'(PERIOD - 1);
			tick <= 1'b1;
		end else begin
			count <= count - COUNT_BITS'(1);
			tick <= 1'b0;
		end
	end

endmodule

/* hdl/uartTransmitter.sv */
`timescale 1ns/1ns
`include "uart_consts.svh"

module uartTransmitter import uartPkg::*; (
	input logic clk,
	input logic rst,
	input logic fifoHasData,
	input uartByte fifoByte,
	input logic tick,
	output logic fifoRead,
	output logic timerRun,
	output logic txd,
	output logic busy
);
	localparam int COUNT_BITS = $clog2(`UART_DATA_BITS);
	localparam logic [COUNT_BITS-1:0] LAST_BIT = COUNT_BITS'(`UART_DATA_BITS - 1);

	serialState state;
	logic [COUNT_BITS-1:0] bitCount;
	uartByte shiftReg;

	// Pop the head byte in the cycle it is captured
	assign fifoRead = (state == stateIdle) && fifoHasData;

	assign timerRun = state != stateIdle;
	assign busy = timerRun || fifoRead;

	// **************************************************
	// Frame sequencer
	// **************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateIdle;
			bitCount <= '0;
			txd <= 1'b1;
		end else begin
			unique case (state)
				stateIdle: begin
					if (fifoHasData) begin
						// Start bit begins with the pop
						txd <= 1'b0;
						state <= stateStart;
					end
				end
				stateStart: begin
					if (tick) begin
						txd <= shiftReg[0];
						bitCount <= '0;
						state <= stateData;
					end
				end
				stateData: begin
					if (tick) begin
						if (bitCount == LAST_BIT) begin
							txd <= 1'b1;
							state <= stateStop;
						end else begin
							txd <= shiftReg[0];
							bitCount <= bitCount + COUNT_BITS'(1);
						end
					end
				end
				stateStop: begin
					if (tick)
						state <= stateIdle;
				end
			endcase
		end
	end

	// Data bits leave LSB first
	always_ff @(posedge clk) begin
		if (fifoRead)
			shiftReg <= fifoByte;
		else if (tick && (state == stateStart || state == stateData))
			shiftReg <= {1'b0, shiftReg[$bits(uartByte)-1:1]};
	end

endmodule

/* hdl/uartReceiver.sv */
`timescale 1ns/1ns
`include "uart_consts.svh"

module uartReceiver import uartPkg::*; (
	input logic clk,
	input logic rst,
	input logic rxd,
	input logic tick,
	output logic timerRun,
	output logic timerHalf,
	output uartByte byteOut,
	output logic byteValid,
	output logic frameError
);
	localparam int COUNT_BITS = $clog2(`UART_DATA_BITS);
	localparam logic [COUNT_BITS-1:0] LAST_BIT = COUNT_BITS'(`UART_DATA_BITS - 1);

	serialState state;
	logic rxMeta;
	logic rxSync;
	logic rxPrev;
	logic startEdge;
	logic [COUNT_BITS-1:0] bitCount;
	uartByte shiftReg;

	// **************************************************
	// Input synchronizer and start detection
	// **************************************************

	// Idle line is high, so the stages reset high
	always_ff @(posedge clk) begin
		if (rst) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end else begin
			rxMeta <= rxd;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
		end
	end

	assign startEdge = rxPrev && !rxSync;

	// Half period first so every later tick lands mid-bit
	assign timerRun = state != stateIdle;
	assign timerHalf = state == stateStart;

	assign byteOut = shiftReg;

	// **************************************************
	// Frame sequencer
	// **************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateIdle;
			bitCount <= '0;
			byteValid <= 1'b0;
			frameError <= 1'b0;
		end else begin
			byteValid <= 1'b0;
			frameError <= 1'b0;
			unique case (state)
				stateIdle: begin
					if (startEdge)
						state <= stateStart;
				end
				stateStart: begin
					if (tick) begin
						// Glitch rather than a real start bit
						if (rxSync) begin
							state <= stateIdle;
						end else begin
							bitCount <= '0;
							state <= stateData;
						end
					end
				end
				stateData: begin
					if (tick) begin
						bitCount <= bitCount + COUNT_BITS'(1);
						if (bitCount == LAST_BIT)
							state <= stateStop;
					end
				end
				stateStop: begin
					if (tick) begin
						state <= stateIdle;
						if (rxSync)
							byteValid <= 1'b1;
						else
							frameError <= 1'b1;
					end
				end
			endcase
		end
	end

	// LSB arrives first and shifts toward bit 0
	always_ff @(posedge clk) begin
		if (tick && state == stateData)
			shiftReg <= {rxSync, shiftReg[$bits(uartByte)-1:1]};
	end

endmodule

/* hdl/uartCore.sv */
`timescale 1ns/1ns
`include "uart_consts.svh"

module uartCore import uartPkg::*; (
	input logic clk,
	input logic rst,
	input uartByte txData,
	input logic txWrite,
	input logic rxd,
	input logic rxRead,
	output logic txFull,
	output logic txLost,
	output logic txBusy,
	output logic txd,
	output uartByte rxData,
	output logic rxReady,
	output logic rxLost,
	output logic frameError
);
	uartByte txHead;
	uartByte rxByte;
	logic txHasData;
	logic txPop;
	logic txRun;
	logic txTick;
	logic rxRun;
	logic rxHalf;
	logic rxTick;
	logic rxByteValid;

	// **************************************************
	// Transmit path
	// **************************************************
	byteFifo #(.ADDR_BITS(`UART_FIFO_ADDR_BITS)) txFifo (
		.clk(clk), .rst(rst),
		.dataIn(txData), .we(txWrite), .oe(txPop),
		.dataOut(txHead), .isData(txHasData),
		.bufferFull(txFull), .dataLost(txLost)
	);

	// Transmit bits start on the edge, no half interval
	baudTimer txTimer (
		.clk(clk), .rst(rst), .run(txRun), .halfFirst(1'b0), .tick(txTick)
	);

	uartTransmitter transmitter (
		.clk(clk), .rst(rst),
		.fifoHasData(txHasData), .fifoByte(txHead), .tick(txTick),
		.fifoRead(txPop), .timerRun(txRun), .txd(txd), .busy(txBusy)
	);

	// **************************************************
	// Receive path
	// **************************************************
	uartReceiver receiver (
		.clk(clk), .rst(rst), .rxd(rxd), .tick(rxTick),
		.timerRun(rxRun), .timerHalf(rxHalf),
		.byteOut(rxByte), .byteValid(rxByteValid), .frameError(frameError)
	);

	baudTimer rxTimer (
		.clk(clk), .rst(rst), .run(rxRun), .halfFirst(rxHalf), .tick(rxTick)
	);

	byteFifo #(.ADDR_BITS(`UART_FIFO_ADDR_BITS)) rxFifo (
		.clk(clk), .rst(rst),
		.dataIn(rxByte), .we(rxByteValid), .oe(rxRead),
		.dataOut(rxData), .isData(rxReady),
		.bufferFull(), .dataLost(rxLost)
	);

endmodule

/* testbench/uartCoreTb.sv */
`timescale 1ns/1ns
`include "uart_consts.svh"

module uartCoreTb import uartPkg::*; ();
	localparam int CLKS = `UART_CLKS_PER_BIT;
	// One FIFO slot always stays empty
	localparam int FIFO_SLOTS = (1 << `UART_FIFO_ADDR_BITS) - 1;
	localparam int FRAME_CYCLES = 10 * CLKS + 4;
	localparam int FRAME_GAP = 8;
	localparam int LOOPBACK_BYTES = 20;

	logic clk;
	logic rst;
	uartByte txData;
	logic txWrite;
	logic rxd;
	logic rxRead;
	logic txFull;
	logic txLost;
	logic txBusy;
	logic txd;
	uartByte rxData;
	logic rxReady;
	logic rxLost;
	logic frameError;
	logic loopback;
	logic rxdDrive;

	int seed = 32'h575c_2860;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int testErrors = 0;
	int frameErrorCycles = 0;
	// Bytes expected on rxData in arrival order
	uartByte rxModel[$];

	uartCore i_uartCore (.*);

	// Receive line from our own txd or from driveFrame
	assign rxd = loopback ? txd : rxdDrive;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(negedge clk) begin
		if (frameError === 1'b1)
			frameErrorCycles++;
	end

	// **************************************************
	// Compare and report
	// **************************************************
	task automatic compareByte(input string name, input uartByte expected,
			input uartByte actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t ns: %s expected 0x%02h, got 0x%02h",
				$time, name, expected, actual);
		end
	endtask

	task automatic compareFlag(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0t ns: %s expected %b, got %b",
				$time, name, expected, actual);
		end
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errorCount == testErrors)
			$display("Test %0d %s: passed", testCount, name);
		else
			$display("Test %0d %s: failed with %0d errors", testCount, name,
				errorCount - testErrors);
		testErrors = errorCount;
	endtask

	// **************************************************
	// Host and line stimulus
	// **************************************************
	task automatic writeTxByte(input uartByte value);
		@(posedge clk);
		txData <= value;
		txWrite <= 1'b1;
		@(posedge clk);
		txWrite <= 1'b0;
	endtask

	task automatic pulseRxRead();
		@(posedge clk);
		rxRead <= 1'b1;
		@(posedge clk);
		rxRead <= 1'b0;
		// Head moves one edge after the strobe is sampled
		@(posedge clk);
	endtask

	// Wait for a received byte, check it against the model, then pop it
	task automatic readExpected();
		int waited;
		waited = 0;
		@(negedge clk);
		while (rxReady !== 1'b1 && waited < 3 * FRAME_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (rxReady !== 1'b1) begin
			$display("Timeout at %0t ns: no received byte after %0d cycles", $time, waited);
			$display("TESTS FAILED");
			$finish;
		end else if (rxModel.size() == 0) begin
			errorCount++;
			$display("Byte 0x%02h received at %0t ns was never sent", rxData, $time);
			pulseRxRead();
		end else begin
			compareByte("rxData", rxModel.pop_front(), rxData);
			pulseRxRead();
		end
	endtask

	// Start bit, data LSB first, then the given stop bit
	task automatic driveFrame(input uartByte value, input logic stopBit);
		logic [`UART_DATA_BITS+1:0] frame;
		int bitIndex;
		frame = {stopBit, value, 1'b0};
		for (bitIndex = 0; bitIndex < `UART_DATA_BITS + 2; bitIndex++) begin
			@(posedge clk);
			rxdDrive <= frame[bitIndex];
			repeat (CLKS - 1) @(posedge clk);
		end
		@(posedge clk);
		rxdDrive <= 1'b1;
		repeat (FRAME_GAP) @(posedge clk);
	endtask

	initial begin
		uartByte value;
		int gap;
		int i;
		int errorCyclesBefore;
		logic lostExpected;
		rst <= 1'b1;
		txData <= '0;
		txWrite <= 1'b0;
		rxRead <= 1'b0;
		rxdDrive <= 1'b1;
		loopback <= 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		@(negedge clk);
		compareFlag("txd", 1'b1, txd);
		compareFlag("txFull", 1'b0, txFull);
		compareFlag("txLost", 1'b0, txLost);
		compareFlag("txBusy", 1'b0, txBusy);
		compareFlag("rxReady", 1'b0, rxReady);
		compareFlag("rxLost", 1'b0, rxLost);
		compareFlag("frameError", 1'b0, frameError);
		finishTest("reset state");

		// Gaps longer than a frame keep the transmit FIFO nearly empty
		fork
			repeat (LOOPBACK_BYTES) begin
				gap = FRAME_CYCLES + FRAME_GAP + ($random(seed) & 63);
				repeat (gap) @(posedge clk);
				@(negedge clk);
				compareFlag("txFull", 1'b0, txFull);
				value = uartByte'($random(seed));
				rxModel.push_back(value);
				writeTxByte(value);
			end
			repeat (LOOPBACK_BYTES) readExpected();
		join
		finishTest("loopback order");

		repeat (FRAME_GAP) @(posedge clk);
		for (i = 0; i < FIFO_SLOTS + 3; i++) begin
			value = uartByte'($random(seed));
			// FIFO capacity plus the byte the idle transmitter pops at once
			if (i < FIFO_SLOTS + 1)
				rxModel.push_back(value);
			@(posedge clk);
			txData <= value;
			txWrite <= 1'b1;
		end
		@(posedge clk);
		txWrite <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		compareFlag("txFull", 1'b1, txFull);
		compareFlag("txLost", 1'b1, txLost);
		// First frame is on the line
		compareFlag("txBusy", 1'b1, txBusy);
		repeat (FIFO_SLOTS + 1) readExpected();
		repeat (2 * FRAME_CYCLES) @(posedge clk);
		@(negedge clk);
		compareFlag("rxReady", 1'b0, rxReady);
		compareFlag("txBusy", 1'b0, txBusy);
		compareFlag("txLost", 1'b1, txLost);
		value = uartByte'($random(seed));
		rxModel.push_back(value);
		writeTxByte(value);
		@(posedge clk);
		@(negedge clk);
		compareFlag("txLost", 1'b0, txLost);
		readExpected();
		finishTest("transmit overflow");

		@(posedge clk);
		loopback <= 1'b0;
		for (i = 0; i <= FIFO_SLOTS; i++) begin
			value = uartByte'($random(seed));
			lostExpected = rxModel.size() >= FIFO_SLOTS;
			if (!lostExpected)
				rxModel.push_back(value);
			driveFrame(value, 1'b1);
			@(negedge clk);
			compareFlag("rxLost", lostExpected, rxLost);
		end
		repeat (FIFO_SLOTS) readExpected();
		@(negedge clk);
		compareFlag("rxReady", 1'b0, rxReady);
		finishTest("receive overflow");

		pulseRxRead();
		@(negedge clk);
		compareByte("rxData", '0, rxData);
		compareFlag("rxReady", 1'b0, rxReady);
		finishTest("empty read");

		errorCyclesBefore = frameErrorCycles;
		driveFrame(uartByte'($random(seed)), 1'b0);
		@(negedge clk);
		compareFlag("frameError single pulse", 1'b1, frameErrorCycles - errorCyclesBefore == 1);
		compareFlag("rxReady", 1'b0, rxReady);
		value = uartByte'($random(seed));
		rxModel.push_back(value);
		driveFrame(value, 1'b1);
		readExpected();
		compareFlag("rxLost", 1'b0, rxLost);
		finishTest("framing error");

		$display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+include
hdl/uartPkg.sv
hdl/byteFifo.sv
hdl/baudTimer.sv
hdl/uartTransmitter.sv
hdl/uartReceiver.sv
hdl/uartCore.sv
testbench/uartCoreTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --timescale 1ns/1ns -j 0
TOP = uartCoreTb
FILELIST = vlog.f
OBJDIR = obj_dir

SIM = $(OBJDIR)/V$(TOP)
SOURCES = $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS = $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJDIR)
